/* include/tcp_cfg.svh */
`ifndef TCP_CFG_SVH
`define TCP_CFG_SVH

// cycles allowed in handshake or closing states
`define TCP_CONN_TIMEOUT 200

// idle cycles after received data before a pure ACK goes out
`define TCP_ACK_TIMEOUT 24

// fixed initial sequence numbers
`define TCP_ISN_SERVER 32'hfeadabba
`define TCP_ISN_CLIENT 32'h12340000

`define TCP_WIN_SIZE 10 // advertised window

`endif

/* source/tcp_pkg.sv */
package tcp_pkg;

  typedef logic [31:0] seq_t;
  typedef logic [15:0] port_t;

  // same bit order as the header flag field
  typedef struct packed {
    logic ns;
    logic cwr;
    logic ece;
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  typedef enum logic [2:0] {
    closed,
    listen,
    syn_sent,
    syn_received,
    established,
    fin_wait,     // own FIN out, waiting for remote FIN
    send_ack,
    last_ack
  } tcp_state_t;

  typedef enum logic [1:0] {
    close_active,
    close_passive,
    close_reset
  } close_t;

  // segment requests from the FSM to the tx builder
  typedef enum logic [2:0] {
    none,
    syn,
    syn_ack,
    ack,
    data,
    fin_ack
  } tx_kind_t;

  typedef struct packed {
    port_t rem_port;
    seq_t  loc_seq;  // next seq to send
    seq_t  loc_ack;  // next seq expected from remote
    seq_t  rem_seq;
    seq_t  isn;
  } tcb_t;

endpackage

/* source/tcp_seg_if.sv */
`timescale 1ns/1ps

// one parsed TCP header, valid for a single cycle
interface tcp_seg_if;

  logic                hdr_v;
  tcp_pkg::port_t      src_port;
  tcp_pkg::port_t      dst_port;
  tcp_pkg::seq_t       seq;
  tcp_pkg::seq_t       ack;
  tcp_pkg::tcp_flags_t flags;
  logic [15:0]         len;    // payload bytes

  modport src (
    output hdr_v, src_port, dst_port, seq, ack, flags, len
  );

  modport snk (
    input hdr_v, src_port, dst_port, seq, ack, flags, len
  );

endinterface

/* source/tcp_rx_filter.sv */
`timescale 1ns/1ps

module tcp_rx_filter (
  input  logic                clk,
  input  logic                tcp_rst,
  input  logic                rx_hdr_v,
  input  tcp_pkg::port_t      rx_src_port,
  input  tcp_pkg::port_t      rx_dst_port,
  input  tcp_pkg::seq_t       rx_seq,
  input  tcp_pkg::seq_t       rx_ack,
  input  tcp_pkg::tcp_flags_t rx_flags,
  input  logic [15:0]         rx_len,
  input  tcp_pkg::port_t      dev_port,
  input  tcp_pkg::tcb_t       tcb,
  tcp_seg_if.src              rx_seg,
  output logic                port_match,
  output logic                conn_match,
  output logic                in_order
);

  logic port_hit;
  logic conn_hit;

  assign port_hit = (rx_dst_port == dev_port);
  assign conn_hit = port_hit && (rx_src_port == tcb.rem_port); // our remote peer

  // strobe and match events
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      rx_seg.hdr_v <= 1'b0;
      port_match   <= 1'b0;
      conn_match   <= 1'b0;
      in_order     <= 1'b0;
    end else begin
      rx_seg.hdr_v <= rx_hdr_v;
      port_match   <= rx_hdr_v && port_hit;
      conn_match   <= rx_hdr_v && conn_hit;
      in_order     <= rx_hdr_v && conn_hit && (rx_seq == tcb.loc_ack);
    end
  end

  // header fields only move with a new header
  always_ff @(posedge clk) begin
    if (rx_hdr_v) begin
      rx_seg.src_port <= rx_src_port;
      rx_seg.dst_port <= rx_dst_port;
      rx_seg.seq      <= rx_seq;
      rx_seg.ack      <= rx_ack;
      rx_seg.flags    <= rx_flags;
      rx_seg.len      <= rx_len;
    end
  end

  // an event always comes with the header that caused it
  a_event_with_hdr : assert property (@(posedge clk) disable iff (tcp_rst)
    (port_match || conn_match || in_order) |->
      rx_seg.hdr_v && (rx_seg.dst_port == dev_port));

endmodule

/* source/tcp_timers.sv */
`timescale 1ns/1ps
`include "tcp_cfg.svh"

module tcp_timers (
  input  logic clk,
  input  logic tcp_rst,
  input  logic handshake_active,
  input  logic data_rx,
  input  logic tx_sent,
  output logic conn_expired,
  output logic force_ack
);

  localparam int CONN_W = $clog2(`TCP_CONN_TIMEOUT + 1);
  localparam int ACK_W  = $clog2(`TCP_ACK_TIMEOUT + 1);

  logic [CONN_W-1:0] conn_cnt;
  logic [ACK_W-1:0]  ack_cnt;

  // handshake / closing watchdog
  always_ff @(posedge clk) begin
    if (tcp_rst) begin
      conn_cnt     <= '0;
      conn_expired <= 1'b0;
    end else begin
      conn_expired <= 1'b0;
      if (!handshake_active) begin
        conn_cnt <= '0;
      end else if (conn_cnt == CONN_W'(`TCP_CONN_TIMEOUT - 1)) begin
        conn_cnt     <= '0;
        conn_expired <= 1'b1;
      end else begin
        conn_cnt <= conn_cnt + 1'b1;
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////////
  // ack timer, idle while saturated at the timeout
  ///////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (tcp_rst || handshake_active) begin // stale acks never cross a handshake
      ack_cnt   <= ACK_W'(`TCP_ACK_TIMEOUT);
      force_ack <= 1'b0;
    end else begin
      if (tx_sent) force_ack <= 1'b0; // any segment carries loc_ack
      if (data_rx) begin
        ack_cnt <= '0;
      end else if (tx_sent) begin
        ack_cnt <= ACK_W'(`TCP_ACK_TIMEOUT);
      end else if (ack_cnt != ACK_W'(`TCP_ACK_TIMEOUT)) begin
        ack_cnt <= ack_cnt + 1'b1;
        if (ack_cnt == ACK_W'(`TCP_ACK_TIMEOUT - 1)) force_ack <= 1'b1;
      end
    end
  end

endmodule

/* source/tcp_tx_builder.sv */
`timescale 1ns/1ps

module tcp_tx_builder (
  input  logic              clk,
  input  logic              tcp_rst,
  input  tcp_pkg::tx_kind_t tx_req,
  input  tcp_pkg::tcb_t     tcb,
  input  tcp_pkg::port_t    dev_port,
  input  tcp_pkg::seq_t     data_seq,
  input  logic [15:0]       data_len,
  input  logic              tx_busy,
  tcp_seg_if.src            tx_seg,
  output logic              tx_sent
);

  tcp_pkg::tcp_flags_t flags;
  tcp_pkg::seq_t       seq;
  tcp_pkg::seq_t       ack;
  logic [15:0]         len;

  // request kind -> header fields
  always_comb begin
    flags     = '0;
    seq       = tcb.loc_seq;
    ack       = tcb.loc_ack;
    len       = '0;
    flags.ack = 1'b1; // all but the first SYN
    case (tx_req)
      tcp_pkg::syn: begin
        flags.ack = 1'b0;
        flags.syn = 1'b1;
        seq       = tcb.isn;
        ack       = '0;
      end
      tcp_pkg::syn_ack: begin
        flags.syn = 1'b1;
        seq       = tcb.isn;
      end
      tcp_pkg::data: begin
        flags.psh = 1'b1;
        seq       = data_seq;
        len       = data_len;
      end
      tcp_pkg::fin_ack: flags.fin = 1'b1;
      default: ;
    endcase
  end

  // header goes out in the first cycle the MAC is free
  assign tx_sent         = (tx_req != tcp_pkg::none) && !tx_busy;
  assign tx_seg.hdr_v    = tx_sent;
  assign tx_seg.src_port = dev_port;
  assign tx_seg.dst_port = tcb.rem_port;
  assign tx_seg.seq      = seq;
  assign tx_seg.ack      = ack;
  assign tx_seg.flags    = flags;
  assign tx_seg.len      = len;

  a_no_hdr_when_busy : assert property (@(posedge clk) disable iff (tcp_rst)
    tx_seg.hdr_v |-> !tx_busy);

  // FSM holds a waiting request, only a connection reset may drop it
  a_req_held : assert property (@(posedge clk) disable iff (tcp_rst)
    (tx_req != tcp_pkg::none) && !tx_sent |=>
      (tx_req == $past(tx_req)) || (tx_req == tcp_pkg::none));

endmodule

/* source/tcp_conn_fsm.sv */
`timescale 1ns/1ps
`include "tcp_cfg.svh"

module tcp_conn_fsm (
  input  logic              clk,
  input  logic              tcp_rst,
  input  logic              listen,
  input  logic              connect,
  input  logic              force_fin,
  input  tcp_pkg::port_t    rem_port,
  tcp_seg_if.snk            rx_seg,
  input  logic              port_match,
  input  logic              conn_match,
  input  logic              in_order,
  input  logic              conn_expired,
  input  logic              force_ack,
  input  logic              queue_pend,
  input  tcp_pkg::seq_t     queue_seq,
  input  logic [15:0]       queue_len,
  input  logic              queue_flushed,
  input  logic              tx_sent,
  output tcp_pkg::tx_kind_t tx_req,
  output tcp_pkg::tcb_t     tcb,
  output tcp_pkg::seq_t     data_seq,
  output logic [15:0]       data_len,
  output logic              handshake_active,
  output logic              data_rx,
  output logic              connected,
  output logic              flush_queue
);

  tcp_pkg::tcp_state_t state;
  tcp_pkg::close_t     close_kind;
  logic                is_server;  // opened by listen
  logic                conn_rst;   // internal connection reset
  logic                tx_idle;
  logic                close_req;
  logic                queue_new;

  assign tx_idle   = (tx_req == tcp_pkg::none);
  assign close_req = force_fin || (is_server ? !listen : !connect);
  // queue entry not yet covered by loc_seq
  assign queue_new = queue_pend && (queue_seq + {16'd0, queue_len} != tcb.loc_seq);

  assign handshake_active = state inside {tcp_pkg::syn_sent, tcp_pkg::syn_received,
                                          tcp_pkg::fin_wait, tcp_pkg::send_ack,
                                          tcp_pkg::last_ack};
  // out-of-order data restarts the ack timer too, so a duplicate ACK goes out
  assign data_rx = (state == tcp_pkg::established) && conn_match && (rx_seg.len != 16'd0);

  // payload of a data request, frozen while it waits
  always_ff @(posedge clk) begin
    if (tx_req != tcp_pkg::data) begin
      data_seq <= queue_seq;
      data_len <= queue_len;
    end
  end

  always_ff @(posedge clk) begin
    if (tcp_rst || conn_rst) begin
      state       <= tcp_pkg::closed;
      close_kind  <= tcp_pkg::close_active;
      is_server   <= 1'b0;
      conn_rst    <= 1'b0;
      tx_req      <= tcp_pkg::none;
      tcb         <= '0;
      connected   <= 1'b0;
      flush_queue <= 1'b0;
    end else begin
      conn_rst <= conn_expired;
      //////////////////////////////////////////////////////////////////////////
      // sent segments advance loc_seq
      //////////////////////////////////////////////////////////////////////////
      if (tx_sent) begin
        tx_req <= tcp_pkg::none;
        case (tx_req)
          tcp_pkg::syn, tcp_pkg::syn_ack, tcp_pkg::fin_ack: tcb.loc_seq <= tcb.loc_seq + 32'd1;
          tcp_pkg::data: tcb.loc_seq <= data_seq + {16'd0, data_len};
          default: ;
        endcase
      end
      case (state)
        tcp_pkg::closed: begin
          if (listen) begin
            is_server <= 1'b1;
            state     <= tcp_pkg::listen;
          end else if (connect) begin
            is_server    <= 1'b0;
            tcb.rem_port <= rem_port;
            tcb.isn      <= `TCP_ISN_CLIENT;
            tcb.loc_seq  <= `TCP_ISN_CLIENT;
            tcb.loc_ack  <= '0;       // unknown until SYN ACK
            tx_req       <= tcp_pkg::syn;
            state        <= tcp_pkg::syn_sent;
          end
        end
        tcp_pkg::listen: begin
          if (!listen) begin
            state <= tcp_pkg::closed;
          end else if (port_match && rx_seg.flags.syn && !rx_seg.flags.ack) begin
            tcb.rem_port <= rx_seg.src_port;
            tcb.rem_seq  <= rx_seg.seq;
            tcb.loc_ack  <= rx_seg.seq + 32'd1;
            tcb.isn      <= `TCP_ISN_SERVER;
            tcb.loc_seq  <= `TCP_ISN_SERVER;
            tx_req       <= tcp_pkg::syn_ack;
            state        <= tcp_pkg::syn_received;
          end
        end
        tcp_pkg::syn_sent: begin
          if (tx_idle && conn_match && rx_seg.flags.syn && rx_seg.flags.ack) begin
            tcb.rem_seq <= rx_seg.seq;
            tcb.loc_ack <= rx_seg.seq + 32'd1;
            tx_req      <= tcp_pkg::ack;
            state       <= tcp_pkg::established;
          end
        end
        tcp_pkg::syn_received: begin
          if (in_order && rx_seg.flags.ack && !rx_seg.flags.syn) begin
            tcb.rem_seq <= rx_seg.seq;
            state       <= tcp_pkg::established;
          end
        end
        tcp_pkg::established: begin
          connected <= 1'b1;
          if (in_order) begin
            tcb.rem_seq <= rx_seg.seq;
            tcb.loc_ack <= tcb.loc_ack + {16'd0, rx_seg.len};
          end
          if (!flush_queue) begin
            if (tx_idle && queue_new) tx_req <= tcp_pkg::data; // data piggybacks the ack
            else if (tx_idle && force_ack) tx_req <= tcp_pkg::ack;
            if (close_req) begin
              flush_queue <= 1'b1;
              close_kind  <= tcp_pkg::close_active;
            end else if (conn_match && rx_seg.flags.fin) begin
              flush_queue <= 1'b1;
              close_kind  <= tcp_pkg::close_passive;
            end else if (conn_match && rx_seg.flags.rst) begin
              flush_queue <= 1'b1;
              close_kind  <= tcp_pkg::close_reset;
            end
          end else if (queue_flushed && tx_idle) begin
            case (close_kind)
              tcp_pkg::close_active: begin
                flush_queue <= 1'b0;
                tx_req      <= tcp_pkg::fin_ack;
                state       <= tcp_pkg::fin_wait;
              end
              tcp_pkg::close_passive: begin
                flush_queue <= 1'b0;
                tcb.loc_ack <= tcb.loc_ack + 32'd1; // remote FIN takes one seq
                tx_req      <= tcp_pkg::ack;
                state       <= tcp_pkg::send_ack;
              end
              default: conn_rst <= 1'b1; // RST, nothing to send
            endcase
          end
        end
        tcp_pkg::fin_wait: begin
          if (tx_idle && conn_match && rx_seg.flags.fin) begin
            tcb.rem_seq <= rx_seg.seq;
            tcb.loc_ack <= tcb.loc_ack + 32'd1;
            tx_req      <= tcp_pkg::ack;
            state       <= tcp_pkg::send_ack;
          end
        end
        tcp_pkg::send_ack: begin
          if (tx_sent && close_kind == tcp_pkg::close_passive) begin
            tx_req <= tcp_pkg::fin_ack;
            state  <= tcp_pkg::last_ack;
          end else if (tx_sent) begin
            conn_rst <= 1'b1; // active close ends on our last ACK
          end
        end
        tcp_pkg::last_ack: begin
          if (tx_idle && conn_match && rx_seg.flags.ack) conn_rst <= 1'b1;
        end
        default: state <= tcp_pkg::closed;
      endcase
    end
  end

  a_connected_state : assert property (@(posedge clk) disable iff (tcp_rst)
    connected |-> state inside {tcp_pkg::established, tcp_pkg::fin_wait,
                                tcp_pkg::send_ack, tcp_pkg::last_ack});

endmodule

/* source/tcp_engine.sv */
`timescale 1ns/1ps

module tcp_engine (
  input  logic                clk,
  input  logic                tcp_rst,
  input  tcp_pkg::port_t      dev_port,
  input  logic                listen,
  input  logic                connect,
  input  logic                force_fin,
  input  tcp_pkg::port_t      rem_port,
  // parsed rx header
  input  logic                rx_hdr_v,
  input  tcp_pkg::port_t      rx_src_port,
  input  tcp_pkg::port_t      rx_dst_port,
  input  tcp_pkg::seq_t       rx_seq,
  input  tcp_pkg::seq_t       rx_ack,
  input  tcp_pkg::tcp_flags_t rx_flags,
  input  logic [15:0]         rx_len,
  input  logic                tx_busy,
  // tx queue control
  input  logic                queue_pend,
  input  tcp_pkg::seq_t       queue_seq,
  input  logic [15:0]         queue_len,
  input  logic                queue_flushed,
  output logic                tx_hdr_v,
  output tcp_pkg::port_t      tx_src_port,
  output tcp_pkg::port_t      tx_dst_port,
  output tcp_pkg::seq_t       tx_seq,
  output tcp_pkg::seq_t       tx_ack,
  output tcp_pkg::tcp_flags_t tx_flags,
  output logic [15:0]         tx_len,
  output logic                connected,
  output logic                flush_queue
);

  tcp_seg_if rx_seg ();
  tcp_seg_if tx_seg ();

  tcp_pkg::tcb_t     tcb;
  tcp_pkg::tx_kind_t tx_req;
  tcp_pkg::seq_t     data_seq;
  logic [15:0]       data_len;
  logic              port_match;
  logic              conn_match;
  logic              in_order;
  logic              conn_expired;
  logic              force_ack;
  logic              handshake_active;
  logic              data_rx;
  logic              tx_sent;

  tcp_rx_filter i_tcp_rx_filter (
    .clk, .tcp_rst, .rx_hdr_v, .rx_src_port, .rx_dst_port, .rx_seq, .rx_ack,
    .rx_flags, .rx_len, .dev_port, .tcb, .rx_seg(rx_seg.src),
    .port_match, .conn_match, .in_order
  );

  tcp_timers i_tcp_timers (
    .clk, .tcp_rst, .handshake_active, .data_rx, .tx_sent, .conn_expired, .force_ack
  );

  tcp_tx_builder i_tcp_tx_builder (
    .clk, .tcp_rst, .tx_req, .tcb, .dev_port, .data_seq, .data_len, .tx_busy,
    .tx_seg(tx_seg.src), .tx_sent
  );

  tcp_conn_fsm i_tcp_conn_fsm (
    .clk, .tcp_rst, .listen, .connect, .force_fin, .rem_port, .rx_seg(rx_seg.snk),
    .port_match, .conn_match, .in_order, .conn_expired, .force_ack,
    .queue_pend, .queue_seq, .queue_len, .queue_flushed, .tx_sent,
    .tx_req, .tcb, .data_seq, .data_len, .handshake_active, .data_rx,
    .connected, .flush_queue
  );

  // tx header onto the MAC side ports
  assign tx_hdr_v    = tx_seg.hdr_v;
  assign tx_src_port = tx_seg.src_port;
  assign tx_dst_port = tx_seg.dst_port;
  assign tx_seq      = tx_seg.seq;
  assign tx_ack      = tx_seg.ack;
  assign tx_flags    = tx_seg.flags;
  assign tx_len      = tx_seg.len;

endmodule

/* testbench/tcp_engine_tb.sv */
`timescale 1ns/1ps
`include "tcp_cfg.svh"

module tcp_engine_tb;

  localparam STIM_FILE = "testbench/tcp_stimulus.txt";
  localparam int WAIT_LIMIT = `TCP_CONN_TIMEOUT + 50; // cycles for one expected event
  localparam logic [15:0] DEV_PORT = 16'h0050;

  // one header seen on the tx ports
  typedef struct packed {
    tcp_pkg::port_t      src;
    tcp_pkg::port_t      dst;
    tcp_pkg::seq_t       seq;
    tcp_pkg::seq_t       ack;
    tcp_pkg::tcp_flags_t flags;
    logic [15:0]         len;
  } seg_rec_t;

  logic                clk;
  logic                tcp_rst;
  tcp_pkg::port_t      dev_port;
  logic                listen;
  logic                connect;
  logic                force_fin;
  tcp_pkg::port_t      rem_port;
  logic                rx_hdr_v;
  tcp_pkg::port_t      rx_src_port;
  tcp_pkg::port_t      rx_dst_port;
  tcp_pkg::seq_t       rx_seq;
  tcp_pkg::seq_t       rx_ack;
  tcp_pkg::tcp_flags_t rx_flags;
  logic [15:0]         rx_len;
  logic                tx_busy;
  logic                queue_pend;
  tcp_pkg::seq_t       queue_seq;
  logic [15:0]         queue_len;
  logic                queue_flushed;
  logic                tx_hdr_v;
  tcp_pkg::port_t      tx_src_port;
  tcp_pkg::port_t      tx_dst_port;
  tcp_pkg::seq_t       tx_seq;
  tcp_pkg::seq_t       tx_ack;
  tcp_pkg::tcp_flags_t tx_flags;
  logic [15:0]         tx_len;
  logic                connected;
  logic                flush_queue;

  logic             busy_en = 1'b0;  // random back-pressure on/off
  integer           seed = 32'h959f;
  int               line_cnt = 0;
  int               errors = 0;
  int               test_errors = 0;
  int               tests_run = 0;
  int               tests_failed = 0;
  int               test_num = 0;
  logic [8*24-1:0]  test_name;
  seg_rec_t         seen_q[$];       // tx headers not yet matched
  seg_rec_t         mon_rec;

  tcp_engine i_tcp_engine (
    .clk, .tcp_rst, .dev_port, .listen, .connect, .force_fin, .rem_port,
    .rx_hdr_v, .rx_src_port, .rx_dst_port, .rx_seq, .rx_ack, .rx_flags, .rx_len,
    .tx_busy, .queue_pend, .queue_seq, .queue_len, .queue_flushed,
    .tx_hdr_v, .tx_src_port, .tx_dst_port, .tx_seq, .tx_ack, .tx_flags, .tx_len,
    .connected, .flush_queue
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // MAC back-pressure, changes on the falling edge only
  initial begin
    integer rnd;
    tx_busy = 1'b0;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      tx_busy = busy_en & rnd[0];
    end
  end

  // collect every tx header, none may go out while busy
  always @(posedge clk) begin
    if (!tcp_rst && tx_hdr_v === 1'b1) begin
      if (tx_busy !== 1'b0) begin
        $display("tx header sent while tx_busy was high at %0t", $time);
        count_error();
      end
      mon_rec = {tx_src_port, tx_dst_port, tx_seq, tx_ack, tx_flags, tx_len};
      seen_q.push_back(mon_rec);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic show_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("** Error: %s got 0x%h, expected 0x%h", sig, got, exp);
    count_error();
  endtask

  task automatic check_seg(input seg_rec_t got, input tcp_pkg::port_t src,
                           input tcp_pkg::port_t dst, input tcp_pkg::seq_t seq,
                           input tcp_pkg::seq_t ack, input tcp_pkg::tcp_flags_t flags,
                           input logic [15:0] len);
    if (got.src !== src) show_mismatch("tx_src_port", got.src, src);
    if (got.dst !== dst) show_mismatch("tx_dst_port", got.dst, dst);
    if (got.seq !== seq) show_mismatch("tx_seq", got.seq, seq);
    if (got.ack !== ack) show_mismatch("tx_ack", got.ack, ack);
    if (got.flags !== flags) show_mismatch("tx_flags", got.flags, flags);
    if (got.len !== len) show_mismatch("tx_len", got.len, len);
  endtask

  task automatic check_level(input string sig, input logic got, input logic exp);
    if (got !== exp) show_mismatch(sig, got, exp);
  endtask

  // one remote header, valid for a single cycle
  task automatic send_rx(input tcp_pkg::port_t src, input tcp_pkg::port_t dst,
                         input tcp_pkg::seq_t seq, input tcp_pkg::seq_t ack,
                         input tcp_pkg::tcp_flags_t flags, input logic [15:0] len);
    @(negedge clk);
    rx_hdr_v    = 1'b1;
    rx_src_port = src;
    rx_dst_port = dst;
    rx_seq      = seq;
    rx_ack      = ack;
    rx_flags    = flags;
    rx_len      = len;
    @(negedge clk);
    rx_hdr_v = 1'b0;
  endtask

  task automatic expect_seg(input tcp_pkg::port_t src, input tcp_pkg::port_t dst,
                            input tcp_pkg::seq_t seq, input tcp_pkg::seq_t ack,
                            input tcp_pkg::tcp_flags_t flags, input logic [15:0] len);
    int       n;
    seg_rec_t got;
    n = 0;
    while (seen_q.size() == 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (seen_q.size() == 0) begin
      $display("no tx segment within %0d cycles, expected flags 0x%h seq 0x%h",
               WAIT_LIMIT, flags, seq);
      count_error();
    end else begin
      got = seen_q.pop_front();
      check_seg(got, src, dst, seq, ack, flags, len);
    end
  endtask

  task automatic expect_levels(input logic exp_conn, input logic exp_flush);
    int n;
    n = 0;
    while ((connected !== exp_conn || flush_queue !== exp_flush) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_level("connected", connected, exp_conn);
    check_level("flush_queue", flush_queue, exp_flush);
  endtask

  // leftover headers are segments nobody asked for
  task automatic finish_test();
    seg_rec_t extra;
    while (seen_q.size() != 0) begin
      extra = seen_q.pop_front();
      $display("unexpected tx segment, flags 0x%h seq 0x%h ack 0x%h",
               extra.flags, extra.seq, extra.ack);
      count_error();
    end
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %0d %0s: %0s, %0d errors", test_num, test_name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus file reader
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int               fd;
    int               c;
    int               r;
    int               n_lines;
    logic [8*8-1:0]   kw;
    logic [8*120-1:0] rest;
    logic [31:0]      arg0;
    logic [31:0]      arg1;
    logic [31:0]      arg2;
    logic [31:0]      arg3;
    logic [31:0]      arg4;
    logic [31:0]      arg5;
    tcp_rst       = 1'b1;
    dev_port      = DEV_PORT;
    listen        = 1'b0;
    connect       = 1'b0;
    force_fin     = 1'b0;
    rem_port      = '0;
    rx_hdr_v      = 1'b0;
    rx_src_port   = '0;
    rx_dst_port   = '0;
    rx_seq        = '0;
    rx_ack        = '0;
    rx_flags      = '0;
    rx_len        = '0;
    queue_pend    = 1'b0;
    queue_seq     = '0;
    queue_len     = '0;
    queue_flushed = 1'b0;
    test_name     = '0;
    n_lines       = 0;

    // line count sizes the watchdog
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("stimulus file %0s could not be opened", STIM_FILE);
      count_error();
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == 10) n_lines++;
        c = $fgetc(fd);
      end
      $fclose(fd);
      line_cnt = n_lines;
      fd = $fopen(STIM_FILE, "r");
    end

    repeat (16) @(posedge clk);
    @(negedge clk);
    tcp_rst = 1'b0;

    if (fd != 0) begin
      kw = '0;
      while ($fscanf(fd, "%s", kw) == 1) begin
        case (kw)
          "#": r = $fgets(rest, fd);
          "test": begin
            test_name = '0;
            r = $fscanf(fd, "%d %s", test_num, test_name);
            test_errors = 0;
          end
          "end": finish_test();
          "listen": begin
            r = $fscanf(fd, "%h", arg0);
            @(negedge clk);
            listen = arg0[0];
          end
          "connect": begin
            r = $fscanf(fd, "%h %h", arg0, arg1);
            @(negedge clk);
            connect  = arg0[0];
            rem_port = arg1[15:0];
          end
          "fin": begin
            r = $fscanf(fd, "%h", arg0);
            @(negedge clk);
            force_fin = arg0[0];
          end
          "queue": begin
            r = $fscanf(fd, "%h %h %h", arg0, arg1, arg2);
            @(negedge clk);
            queue_pend = arg0[0];
            queue_seq  = arg1;
            queue_len  = arg2[15:0];
          end
          "flushed": begin
            r = $fscanf(fd, "%h", arg0);
            @(negedge clk);
            queue_flushed = arg0[0];
          end
          "busy": begin
            r = $fscanf(fd, "%h", arg0);
            @(negedge clk);
            busy_en <= arg0[0];
          end
          "rx": begin
            r = $fscanf(fd, "%h %h %h %h %h %h", arg0, arg1, arg2, arg3, arg4, arg5);
            send_rx(arg0[15:0], arg1[15:0], arg2, arg3, arg4[8:0], arg5[15:0]);
          end
          "seg": begin
            r = $fscanf(fd, "%h %h %h %h %h %h", arg0, arg1, arg2, arg3, arg4, arg5);
            expect_seg(arg0[15:0], arg1[15:0], arg2, arg3, arg4[8:0], arg5[15:0]);
          end
          "level": begin
            r = $fscanf(fd, "%h %h", arg0, arg1);
            expect_levels(arg0[0], arg1[0]);
          end
          "expire": repeat (`TCP_CONN_TIMEOUT + 10) @(negedge clk); // past the handshake limit
          default: begin
            $display("unknown stimulus step %0s", kw);
            count_error();
          end
        endcase
        kw = '0;
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // each file line gets at most one full wait
  initial begin
    wait (line_cnt > 0);
    repeat (line_cnt * WAIT_LIMIT + 16) @(posedge clk);
    $display("watchdog expired after %0d cycles, stimulus run did not finish",
             line_cnt * WAIT_LIMIT + 16);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* testbench/tcp_stimulus.txt */
# steps, values in hex: listen v | connect v rem_port | fin v | queue pend seq len | flushed v
# busy v | rx/seg src dst seq ack flags len | level connected flush_queue | expire | test n name | end
test 1 passive_open
listen 1
rx c000 0050 00001000 00000000 002 0000
seg 0050 c000 feadabba 00001001 012 0000
rx c000 0050 00001001 feadabbb 010 0000
level 1 0
end
# in-order data then a wrong seq, both answered by a forced ACK
test 2 rx_ack_timer
rx c000 0050 00001001 feadabbb 018 0020
seg 0050 c000 feadabbb 00001021 010 0000
rx c000 0050 00005555 feadabbb 018 0010
seg 0050 c000 feadabbb 00001021 010 0000
level 1 0
end
test 3 tx_backpressure
busy 1
queue 1 feadabbb 0040
seg 0050 c000 feadabbb 00001021 018 0040
queue 0 00000000 0000
end
test 4 passive_close
rx c000 0050 00001021 feadabfb 011 0000
level 1 1
flushed 1
seg 0050 c000 feadabfb 00001022 010 0000
seg 0050 c000 feadabfb 00001022 011 0000
flushed 0
rx c000 0050 00001022 feadabfc 010 0000
level 0 0
listen 0
end
test 5 active_open_rst
connect 1 d000
seg 0050 d000 12340000 00000000 002 0000
rx d000 0050 77770000 12340001 012 0000
seg 0050 d000 12340001 77770001 010 0000
level 1 0
rx d000 0050 77770001 12340001 004 0000
level 1 1
connect 0 d000
flushed 1
level 0 0
flushed 0
end
# unanswered SYN ACK, engine falls back to listen
test 6 handshake_timeout
listen 1
rx e000 0050 00002000 00000000 002 0000
seg 0050 e000 feadabba 00002001 012 0000
expire
rx e000 0050 00003000 00000000 002 0000
seg 0050 e000 feadabba 00003001 012 0000
level 0 0
end

/* project.f */
+incdir+include
source/tcp_pkg.sv
source/tcp_seg_if.sv
source/tcp_rx_filter.sv
source/tcp_timers.sv
source/tcp_tx_builder.sv
source/tcp_conn_fsm.sv
source/tcp_engine.sv
testbench/tcp_engine_tb.sv

/* Bender.yml */
package:
  name: tcp_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tcp_pkg.sv
      - source/tcp_seg_if.sv
      - source/tcp_rx_filter.sv
      - source/tcp_timers.sv
      - source/tcp_tx_builder.sv
      - source/tcp_conn_fsm.sv
      - source/tcp_engine.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tcp_engine_tb.sv
